/* src/ghost_pkg.sv */
package ghost_pkg;

	// ==========================================================================
	// Block geometry
	// ==========================================================================
	localparam int NIBBLE_W      = 4;
	localparam int BLOCK_NIBBLES = 1024;	// One 512-byte SD block
	localparam int ADDR_W        = 10;
	localparam int CNT_W         = ADDR_W + 1;	// Reaches one past the last address

	// ==========================================================================
	// Keystream
	// ==========================================================================
	// Seed is KEY ^ IV, reloaded on a new pad request
	localparam logic [31:0] KEY = 32'h6a09e667;
	localparam logic [31:0] IV  = 32'hbb67ae85;

	// xorshift32 shift amounts
	localparam int XS_SHL_A = 13;
	localparam int XS_SHR_B = 17;
	localparam int XS_SHL_C = 5;

	// Line framing
	localparam logic [NIBBLE_W-1:0] IDLE_NIBBLE  = 4'hF;	// Idle line and end nibble
	localparam logic [NIBBLE_W-1:0] START_NIBBLE = 4'h0;	// Opens a frame

	// ==========================================================================
	// Types
	// ==========================================================================
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_GEN_PAD,	// Waiting on otp_gen
		ST_WAIT_START,
		ST_RECV,
		ST_CHECK_END,
		ST_SEND_START,
		ST_SEND_DATA,
		ST_SEND_END,
		ST_REPORT
	} engine_state_t;

	// One write into a block buffer
	typedef struct packed {
		logic [ADDR_W-1:0]   addr;
		logic [NIBBLE_W-1:0] data;
		logic                we;
	} ram_wr_t;

	// Outgoing data line
	typedef struct packed {
		logic [NIBBLE_W-1:0] data;
		logic                oe;
	} sd_data_t;

endpackage

/* src/otp_gen.sv */
`timescale 1ns/1ns

module otp_gen import ghost_pkg::*; (
	input  logic    iclk,
	input  logic    reset,
	input  logic    gen_otp,
	input  logic    new_otp,
	output ram_wr_t otp_wr,
	output logic    otp_done
);

	logic [31:0]       xs_state;	// Kept across blocks
	logic [31:0]       xs_next;
	logic              busy;
	logic [ADDR_W-1:0] addr;
	logic              done;

	// One xorshift32 step
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << XS_SHL_A);
		y = y ^ (y >> XS_SHR_B);
		y = y ^ (y << XS_SHL_C);
		return y;
	endfunction

	assign xs_next = xorshift32(xs_state);

	// ==========================================================================
	// Control
	// ==========================================================================
	always_ff @(posedge iclk) begin
		if (reset) begin
			busy <= 1'b0;
			addr <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (busy) begin
				addr <= addr + 1'b1;
				if (addr == ADDR_W'(BLOCK_NIBBLES - 1)) begin
					busy <= 1'b0;
					done <= 1'b1;	// Cycle after the last write
				end
			end else if (gen_otp) begin
				busy <= 1'b1;
				addr <= '0;
			end
		end
	end

	// Generator state steps once per pad nibble and reloads on request
	always_ff @(posedge iclk) begin
		if (busy)
			xs_state <= xs_next;
		else if (gen_otp && new_otp)
			xs_state <= KEY ^ IV;
	end

	// Low nibble of each new state is one pad nibble
	assign otp_wr.addr = addr;
	assign otp_wr.data = xs_next[NIBBLE_W-1:0];
	assign otp_wr.we   = busy;

	assign otp_done = done;

endmodule

/* src/ram_4k_block.sv */
`timescale 1ns/1ns

// 1024 x 4 bit buffer for the pad or the raw block
module ram_4k_block import ghost_pkg::*; (
	input  logic                iclk,
	input  ram_wr_t             wr,
	input  logic [ADDR_W-1:0]   rd_addr,
	output logic [NIBBLE_W-1:0] rd_data
);

	logic [NIBBLE_W-1:0] mem [BLOCK_NIBBLES];

	always_ff @(posedge iclk) begin
		if (wr.we)
			mem[wr.addr] <= wr.data;
	end

	// Read data one cycle after the address
	always_ff @(posedge iclk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

/* src/sd_block_engine.sv */
`timescale 1ns/1ns

module sd_block_engine import ghost_pkg::*; (
	input  logic                iclk,
	input  logic                reset,
	input  logic                start,
	input  logic                otp_done,
	input  logic [NIBBLE_W-1:0] sd_in,
	input  logic [NIBBLE_W-1:0] cipher_nibble,
	output logic                gen_otp,
	output ram_wr_t             raw_wr,
	output logic [ADDR_W-1:0]   rd_addr,
	output sd_data_t            sd_out,
	output logic                success,
	output logic                fail
);

	engine_state_t state;
	engine_state_t state_next;

	// Shared by receive and send
	logic [CNT_W-1:0] cnt;

	logic last_rx;
	logic last_tx;
	logic end_ok;

	assign last_rx = (cnt == CNT_W'(BLOCK_NIBBLES - 1));
	assign last_tx = (cnt == CNT_W'(BLOCK_NIBBLES));	// Last cipher nibble on the read port
	assign end_ok  = (sd_in == IDLE_NIBBLE);

	// Pad request straight from the start strobe
	assign gen_otp = (state == ST_IDLE) && start;

	// ==========================================================================
	// Next state
	// ==========================================================================
	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (start)
					state_next = ST_GEN_PAD;
			end
			ST_GEN_PAD: begin
				if (otp_done)
					state_next = ST_WAIT_START;
			end
			ST_WAIT_START: begin
				if (sd_in == START_NIBBLE)
					state_next = ST_RECV;
			end
			ST_RECV: begin
				if (last_rx)
					state_next = ST_CHECK_END;
			end
			ST_CHECK_END: begin
				state_next = end_ok ? ST_SEND_START : ST_IDLE;
			end
			ST_SEND_START: state_next = ST_SEND_DATA;
			ST_SEND_DATA: begin
				if (last_tx)
					state_next = ST_SEND_END;
			end
			ST_SEND_END: state_next = ST_REPORT;
			ST_REPORT:   state_next = ST_IDLE;
			default:     state_next = ST_IDLE;
		endcase
	end

	// ==========================================================================
	// Registers
	// ==========================================================================
	always_ff @(posedge iclk) begin
		if (reset) begin
			state       <= ST_IDLE;
			cnt         <= '0;
			sd_out.data <= IDLE_NIBBLE;
			sd_out.oe   <= 1'b0;
			success     <= 1'b0;
			fail        <= 1'b0;
		end else begin
			state   <= state_next;
			success <= 1'b0;
			fail    <= 1'b0;
			case (state)
				ST_WAIT_START: cnt <= '0;	// Frame starts at address 0
				ST_RECV: cnt <= cnt + 1'b1;
				ST_CHECK_END: begin
					cnt <= '0;
					if (!end_ok)
						fail <= 1'b1;	// Bad end nibble aborts the block
				end
				ST_SEND_START: begin
					// Address 0 is being read while the start nibble goes out
					cnt         <= cnt + 1'b1;
					sd_out.data <= START_NIBBLE;
					sd_out.oe   <= 1'b1;
				end
				ST_SEND_DATA: begin
					cnt         <= cnt + 1'b1;
					sd_out.data <= cipher_nibble;	// Word for cnt - 1
				end
				ST_SEND_END: sd_out.data <= IDLE_NIBBLE;
				ST_REPORT: begin
					sd_out.oe <= 1'b0;
					success   <= 1'b1;
				end
				default: begin
					sd_out.data <= IDLE_NIBBLE;
					sd_out.oe   <= 1'b0;
				end
			endcase
		end
	end

	// ==========================================================================
	// Buffer ports
	// ==========================================================================
	// Read address runs one ahead of the line output during send
	assign rd_addr = cnt[ADDR_W-1:0];

	// Raw nibbles land in address order
	assign raw_wr.addr = cnt[ADDR_W-1:0];
	assign raw_wr.data = sd_in;
	assign raw_wr.we   = (state == ST_RECV);

endmodule

/* src/ghost_sd.sv */
`timescale 1ns/1ns

module ghost_sd import ghost_pkg::*; (
	input  logic                iclk,
	input  logic                reset,
	input  logic                start,
	input  logic                new_otp,	// 1 reloads the pad seed
	input  logic [NIBBLE_W-1:0] sd_in,
	output logic [NIBBLE_W-1:0] sd_data_out,
	output logic                sd_data_oe,
	output logic                success,
	output logic                fail
);

	logic gen_otp;
	logic otp_done;

	ram_wr_t otp_wr;
	ram_wr_t raw_wr;

	logic [ADDR_W-1:0]   rd_addr;	// Common to both buffers
	logic [NIBBLE_W-1:0] otp_nibble;
	logic [NIBBLE_W-1:0] raw_nibble;
	logic [NIBBLE_W-1:0] cipher_nibble;

	sd_data_t sd_out;

	// ==========================================================================
	// Pad generation and buffers
	// ==========================================================================
	otp_gen otp_gen_inst (
		.iclk     (iclk),
		.reset    (reset),
		.gen_otp  (gen_otp),
		.new_otp  (new_otp),
		.otp_wr   (otp_wr),
		.otp_done (otp_done)
	);

	ram_4k_block otp_block (
		.iclk    (iclk),
		.wr      (otp_wr),
		.rd_addr (rd_addr),
		.rd_data (otp_nibble)
	);

	ram_4k_block raw_block (
		.iclk    (iclk),
		.wr      (raw_wr),
		.rd_addr (rd_addr),
		.rd_data (raw_nibble)
	);

	assign cipher_nibble = raw_nibble ^ otp_nibble;	// Same address, same cycle

	// ==========================================================================
	// Block sequencing
	// ==========================================================================
	sd_block_engine engine_inst (
		.iclk          (iclk),
		.reset         (reset),
		.start         (start),
		.otp_done      (otp_done),
		.sd_in         (sd_in),
		.cipher_nibble (cipher_nibble),
		.gen_otp       (gen_otp),
		.raw_wr        (raw_wr),
		.rd_addr       (rd_addr),
		.sd_out        (sd_out),
		.success       (success),
		.fail          (fail)
	);

	// Pin level data and enable
	assign sd_data_out = sd_out.data;
	assign sd_data_oe  = sd_out.oe;

endmodule

/* sim/tb_ghost_sd.sv */
`timescale 1ns/1ns

module tb_ghost_sd import ghost_pkg::*; ();

	localparam logic [31:0] RAND_SEED    = 32'h4d9f0cf8;
	localparam int          PAD_WAIT     = 1030;	// Generation needs 1026 cycles
	localparam int          BLOCK_CYCLES = 3100;	// Generate, receive, send, margin
	localparam int          TIMEOUT_CYCLES = 6 * BLOCK_CYCLES + 6400;

	logic                iclk;
	logic                reset;
	logic                start;
	logic                new_otp;
	logic [NIBBLE_W-1:0] sd_in;
	logic [NIBBLE_W-1:0] sd_data_out;
	logic                sd_data_oe;
	logic                success;
	logic                fail;

	logic [NIBBLE_W-1:0] blk_in  [BLOCK_NIBBLES];
	logic [NIBBLE_W-1:0] pad_ref [BLOCK_NIBBLES];
	logic [NIBBLE_W-1:0] exp_out [BLOCK_NIBBLES];
	logic [NIBBLE_W-1:0] plain1  [BLOCK_NIBBLES];
	logic [NIBBLE_W-1:0] cipher1 [BLOCK_NIBBLES];

	logic [31:0] rand_state;
	logic [31:0] ref_state;	// Reference copy of the pad generator
	string       test_name;
	logic        frame_expected;
	logic        expect_fail;
	int          idx;	// Nibbles seen with oe high in the current frame
	int          frames_done;
	int          fails_seen;
	int          cycle_count;

	ghost_sd i_ghost_sd (
		.iclk        (iclk),
		.reset       (reset),
		.start       (start),
		.new_otp     (new_otp),
		.sd_in       (sd_in),
		.sd_data_out (sd_data_out),
		.sd_data_oe  (sd_data_oe),
		.success     (success),
		.fail        (fail)
	);

	always #5 iclk = ~iclk;

	// ==========================================================================
	// Reference model
	// ==========================================================================
	function automatic logic [31:0] xorshift_step(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [3:0] rand_nibble();
		rand_state = xorshift_step(rand_state);
		return rand_state[3:0];
	endfunction

	// Pad for one block takes the low nibble after every step
	function automatic void ref_keystream(input logic reload);
		if (reload)
			ref_state = KEY ^ IV;
		for (int i = 0; i < BLOCK_NIBBLES; i++) begin
			ref_state = xorshift_step(ref_state);
			pad_ref[i] = ref_state[3:0];
		end
	endfunction

	function automatic void fill_random_block();
		for (int i = 0; i < BLOCK_NIBBLES; i++)
			blk_in[i] = rand_nibble();
	endfunction

	function automatic void expect_input_xor_pad();
		for (int i = 0; i < BLOCK_NIBBLES; i++)
			exp_out[i] = blk_in[i] ^ pad_ref[i];
	endfunction

	// ==========================================================================
	// Checks
	// ==========================================================================
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_nibble(input string name, input logic [3:0] expected,
			input logic [3:0] actual);
		if (actual !== expected)
			fail_run($sformatf("Mismatch in %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic check_status(input string name, input logic exp_success, input logic exp_fail,
			input logic act_success, input logic act_fail);
		if (act_success !== exp_success || act_fail !== exp_fail)
			fail_run($sformatf(
				"Mismatch in %s: expected success=%b fail=%b, actual success=%b fail=%b",
				name, exp_success, exp_fail, act_success, act_fail));
	endtask

	always @(posedge iclk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			fail_run($sformatf("Timeout after %0d cycles in %s, a frame or pulse never came",
				cycle_count, test_name));
	end

	// Frame monitor samples where the outputs are stable
	always @(negedge iclk) begin
		if (!reset) begin
			if (sd_data_oe) begin
				if (!frame_expected)
					fail_run($sformatf("Output enable rose in %s where no frame was due",
						test_name));
				if (idx == 0)
					check_nibble({test_name, " start nibble"}, START_NIBBLE, sd_data_out);
				else if (idx <= BLOCK_NIBBLES)
					check_nibble($sformatf("%s nibble %0d", test_name, idx - 1), exp_out[idx - 1],
						sd_data_out);
				else if (idx == BLOCK_NIBBLES + 1)
					check_nibble({test_name, " end nibble"}, IDLE_NIBBLE, sd_data_out);
				else
					fail_run($sformatf("Frame in %s is longer than expected", test_name));
				if (success || fail)
					fail_run($sformatf("Status pulse in %s while the frame was on the line",
						test_name));
				idx++;
			end else if (idx != 0) begin
				if (idx != BLOCK_NIBBLES + 2)
					fail_run($sformatf("Frame in %s ended after %0d nibbles", test_name, idx));
				check_status({test_name, " status"}, 1'b1, 1'b0, success, fail);
				frames_done++;
				idx = 0;
			end else begin
				if (success)
					fail_run($sformatf("Success pulse in %s without a frame", test_name));
				if (fail && expect_fail)
					fails_seen++;
				else if (fail)
					fail_run($sformatf("Fail pulse in %s without a bad end nibble", test_name));
			end
		end
	end

	// ==========================================================================
	// Stimulus
	// ==========================================================================
	task automatic run_block(input logic reload, input logic good_end, input logic extra_start);
		int n_frames;
		int n_fails;
		n_frames = frames_done;
		n_fails  = fails_seen;
		start    = 1'b1;
		new_otp  = reload;
		@(negedge iclk);
		start = 1'b0;
		repeat (PAD_WAIT) @(negedge iclk);
		frame_expected = good_end;
		expect_fail    = !good_end;
		sd_in = START_NIBBLE;
		@(negedge iclk);
		for (int i = 0; i < BLOCK_NIBBLES; i++) begin
			sd_in = blk_in[i];
			start = extra_start && (i == BLOCK_NIBBLES / 2);	// Must be ignored
			@(negedge iclk);
		end
		start = 1'b0;
		sd_in = good_end ? IDLE_NIBBLE : 4'h5;
		@(negedge iclk);
		sd_in = IDLE_NIBBLE;
		if (good_end) begin
			while (frames_done == n_frames)
				@(negedge iclk);
		end else begin
			repeat (8) @(negedge iclk);
			if (fails_seen == n_fails)
				fail_run("No fail pulse after a bad end nibble");
			repeat (20) @(negedge iclk);	// Line has to stay quiet
		end
		frame_expected = 1'b0;
		expect_fail    = 1'b0;
		repeat (4) @(negedge iclk);
	endtask

	initial begin
		iclk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		new_otp = 1'b0;
		sd_in = IDLE_NIBBLE;
		rand_state = RAND_SEED;
		ref_state = '0;
		test_name = "reset";
		frame_expected = 1'b0;
		expect_fail = 1'b0;
		idx = 0;
		frames_done = 0;
		fails_seen = 0;
		cycle_count = 0;
		repeat (10) @(negedge iclk);
		reset = 1'b0;

		test_name = "after_reset";
		repeat (20) begin
			@(negedge iclk);
			if (sd_data_oe)
				fail_run("Output enable high before any start");
			check_status(test_name, 1'b0, 1'b0, success, fail);
		end

		test_name = "first_block";
		fill_random_block();
		ref_keystream(1'b1);
		expect_input_xor_pad();
		plain1 = blk_in;
		cipher1 = exp_out;
		run_block(1'b1, 1'b1, 1'b0);

		test_name = "continued_pad";	// Pad nibbles 1024 to 2047
		fill_random_block();
		ref_keystream(1'b0);
		expect_input_xor_pad();
		run_block(1'b0, 1'b1, 1'b0);

		// Reloaded pad turns the first cipher back into the first plaintext
		test_name = "reload_decrypt";
		ref_keystream(1'b1);
		blk_in = cipher1;
		exp_out = plain1;
		run_block(1'b1, 1'b1, 1'b0);

		test_name = "bad_end_nibble";
		fill_random_block();
		ref_keystream(1'b0);
		run_block(1'b0, 1'b0, 1'b0);

		test_name = "start_during_receive";
		fill_random_block();
		ref_keystream(1'b0);
		expect_input_xor_pad();
		run_block(1'b0, 1'b1, 1'b1);

		if (frames_done == 4 && fails_seen == 1) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			fail_run($sformatf("Run ended with %0d frames and %0d fail pulses", frames_done,
				fails_seen));
		end
	end

endmodule

/* all.f */
src/ghost_pkg.sv
src/otp_gen.sv
src/ram_4k_block.sv
src/sd_block_engine.sv
src/ghost_sd.sv
sim/tb_ghost_sd.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of tb_ghost_sd, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f all.f --top-module tb_ghost_sd -o tb_ghost_sd > sim.log 2>&1 &&
	./obj_dir/tb_ghost_sd >> sim.log 2>&1
cat sim.log
grep -q "SIMULATION PASSED" sim.log && echo "run_sim: pass" || {
	echo "run_sim: fail"
	exit 1
}
